// ==== all.f ====
rtl/cpu_types_pkg.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/exec_mem.sv
rtl/mem_stage.sv
rtl/mem_wb.sv
rtl/ex_mem_top.sv
dv/ex_mem_chk.sv
dv/ex_mem_tb.sv

// ==== dv/ex_mem_chk.sv ====
// assertions on the ex/mem latch and the writeback outputs, bound into the top level.
`timescale 1ns/1ns

module ex_mem_chk (
    input logic                     CLK,
    input logic                     nRST,
    input cpu_types_pkg::ex_mem_t   ex_q,
    input cpu_types_pkg::redirect_t redirect,
    input logic                     wb_en,
    input logic                     halt
);

    int   assert_fails = 0;
    logic seen_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            seen_valid <= 1'b0;
        end else if (ex_q.valid) begin
            seen_valid <= 1'b1; // first real instruction reached memory.
        end
    end

    quiet_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
        !seen_valid |-> (!wb_en && !halt))
    else begin
        $error("wb_en or halt high before any valid instruction");
        assert_fails++;
    end

    halt_holds: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else begin
        $error("halt dropped without reset");
        assert_fails++;
    end

    redirect_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
        redirect.taken |-> ex_q.valid)
    else begin
        $error("redirect taken for an invalid bundle");
        assert_fails++;
    end

    no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(ex_q.dren && ex_q.dwen))
    else begin
        $error("dren and dwen both set in ex_q");
        assert_fails++;
    end

endmodule

// ==== dv/ex_mem_tb.sv ====
// directed testbench for the execute and memory pipeline half, with reference model.
`timescale 1ns/1ns

module ex_mem_tb;

    localparam int DMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 8;
    localparam int ALU_REPS     = 3;
    localparam int MEM_WORDS    = 16; // words touched by the memory tests.
    localparam int STREAM_LEN   = 48;
    localparam int TEST_STEPS   = 3 + (10 * ALU_REPS + 4) + (3 * MEM_WORDS + 18) + 9
                                + (STREAM_LEN + 2) + 9;
    localparam int MAX_CYCLES   = RESET_CYCLES + TEST_STEPS + 40;

    logic                     CLK;
    logic                     nRST;
    cpu_types_pkg::id_ex_t    id_ex;
    cpu_types_pkg::redirect_t redirect;
    logic                     wb_en;
    cpu_types_pkg::regbits_t  wb_sel;
    cpu_types_pkg::word_t     wb_data;
    logic                     halt;

    integer seed;
    int     cycles;
    int     word_errs;
    int     reg_errs;
    int     bit_errs;
    int     redir_errs;
    int     total_errs;

    // model pipeline. s1 issued one step back, s2 two steps back.
    cpu_types_pkg::redirect_t s1_redir;
    logic                     s1_en;
    logic                     s2_en;
    cpu_types_pkg::regbits_t  s1_sel;
    cpu_types_pkg::regbits_t  s2_sel;
    cpu_types_pkg::word_t     s1_data;
    cpu_types_pkg::word_t     s2_data;
    logic                     s1_halt;
    logic                     s2_halt;
    logic                     exp_halt;
    cpu_types_pkg::word_t     shadow [DMEM_WORDS];

    ex_mem_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) ex_mem_top_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .id_ex    (id_ex),
        .redirect (redirect),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .halt     (halt)
    );

    bind ex_mem_top ex_mem_chk chk_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .ex_q     (ex_q),
        .redirect (redirect),
        .wb_en    (wb_en),
        .halt     (halt)
    );

    always #50 CLK = ~CLK;

    task automatic check_word(input string name, input cpu_types_pkg::word_t got,
                              input cpu_types_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_reg(input string name, input cpu_types_pkg::regbits_t got,
                             input cpu_types_pkg::regbits_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            reg_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            bit_errs++;
        end
    endtask

    // target only matters when the redirect is taken.
    task automatic check_redirect(input cpu_types_pkg::redirect_t got,
                                  input cpu_types_pkg::redirect_t exp);
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            $display("** Error at %0t: redirect = %b/%h, expected %b/%h", $time,
                     got.taken, got.target, exp.taken, exp.target);
            redir_errs++;
        end
    endtask

    function automatic cpu_types_pkg::word_t alu_model(input cpu_types_pkg::id_ex_t b);
        cpu_types_pkg::word_t x;
        cpu_types_pkg::word_t y;
        x = b.lui ? 32'h0 : b.rdat1;
        y = b.lui ? (b.imm_ext << 16) : (b.alu_src_imm ? b.imm_ext : b.rdat2);
        case (b.alu_op)
            cpu_types_pkg::ALU_SLL:  alu_model = y << b.shift_amt;
            cpu_types_pkg::ALU_SRL:  alu_model = y >> b.shift_amt;
            cpu_types_pkg::ALU_ADD:  alu_model = x + y;
            cpu_types_pkg::ALU_SUB:  alu_model = x - y;
            cpu_types_pkg::ALU_AND:  alu_model = x & y;
            cpu_types_pkg::ALU_OR:   alu_model = x | y;
            cpu_types_pkg::ALU_XOR:  alu_model = x ^ y;
            cpu_types_pkg::ALU_NOR:  alu_model = ~(x | y);
            cpu_types_pkg::ALU_SLT:  alu_model = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            cpu_types_pkg::ALU_SLTU: alu_model = (x < y) ? 32'd1 : 32'd0;
            default:                 alu_model = 32'h0;
        endcase
    endfunction

    // checks the two older instructions, predicts b, drives it, waits one clock.
    task automatic step(input cpu_types_pkg::id_ex_t b);
        cpu_types_pkg::word_t res;
        int                   idx;
        check_redirect(redirect, s1_redir);
        exp_halt = exp_halt | s2_halt;
        check_bit("wb_en", wb_en, s2_en);
        if (s2_en) begin
            check_reg("wb_sel", wb_sel, s2_sel);
            check_word("wb_data", wb_data, s2_data);
        end
        check_bit("halt", halt, exp_halt);
        s2_en   = s1_en;
        s2_sel  = s1_sel;
        s2_data = s1_data;
        s2_halt = s1_halt;
        res = alu_model(b);
        idx = (res >> 2) % DMEM_WORDS;
        s1_redir.taken = b.valid && (b.jr || b.jump || b.jal
                         || (b.beq && res == 0) || (b.bne && res != 0));
        if (b.jr) begin
            s1_redir.target = b.rdat1;
        end else if (b.jump || b.jal) begin
            s1_redir.target = {b.pcplusfour[31:28], b.j_addr, 2'b00};
        end else begin
            s1_redir.target = b.pcplusfour + (b.imm_ext << 2);
        end
        s1_en   = b.valid && b.reg_wr;
        s1_sel  = b.wsel;
        s1_data = b.jal ? b.pcplusfour : (b.mem_to_reg ? shadow[idx] : res);
        s1_halt = b.valid && b.halt;
        if (b.valid && b.dwen) begin
            shadow[idx] = b.rdat2;
        end
        id_ex = b;
        @(negedge CLK);
    endtask

    task automatic random_instr(output cpu_types_pkg::id_ex_t b);
        b            = '0;
        b.valid      = 1'b1;
        b.alu_op     = cpu_types_pkg::ALU_ADD;
        b.shift_amt  = $random(seed);
        b.rdat1      = $random(seed);
        b.rdat2      = $random(seed);
        b.imm_ext    = $random(seed);
        b.j_addr     = $random(seed);
        b.pcplusfour = $random(seed) & 32'hFFFF_FFFC;
        b.wsel       = $random(seed);
        b.reg_wr     = 1'b1;
    endtask

    // load or store of word idx, upper address bits random to exercise the wrap.
    task automatic mem_instr(output cpu_types_pkg::id_ex_t b, input logic store, input int idx);
        cpu_types_pkg::word_t addr;
        random_instr(b);
        addr          = ($random(seed) & ~((DMEM_WORDS - 1) << 2)) | (idx << 2);
        b.alu_src_imm = 1'b1;
        b.imm_ext     = addr - b.rdat1;
        b.dwen        = store;
        b.dren        = !store;
        b.mem_to_reg  = !store;
        b.reg_wr      = !store;
    endtask

    task automatic drain();
        step('0);
        step('0);
    endtask

    task automatic test_reset();
        cpu_types_pkg::id_ex_t b;
        check_bit("redirect.taken", redirect.taken, 1'b0);
        check_bit("wb_en", wb_en, 1'b0);
        check_bit("halt", halt, 1'b0);
        repeat (3) begin
            random_instr(b);
            b.valid = 1'b0; // bubble with live control bits.
            b.jump  = 1'b1;
            b.dwen  = 1'b1;
            b.halt  = 1'b1;
            step(b);
        end
    endtask

    task automatic test_alu();
        cpu_types_pkg::id_ex_t b;
        for (int op = 0; op < 10; op++) begin
            for (int rep = 0; rep < ALU_REPS; rep++) begin
                random_instr(b);
                b.alu_op      = op[3:0];
                b.alu_src_imm = (rep == 1);
                step(b);
            end
        end
        random_instr(b);
        b.lui = 1'b1;
        step(b);
        random_instr(b);
        b.lui    = 1'b1;
        b.alu_op = cpu_types_pkg::ALU_OR;
        step(b);
        drain();
    endtask

    task automatic test_mem();
        cpu_types_pkg::id_ex_t b;
        int                    idx;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_instr(b, 1'b1, i);
            step(b);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_instr(b, 1'b0, i);
            step(b);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_instr(b, 1'b0, (i * 5 + 3) % MEM_WORDS); // scrambled order.
            step(b);
        end
        repeat (4) begin
            idx = {$random(seed)} % MEM_WORDS;
            mem_instr(b, 1'b1, idx);
            step(b);
            mem_instr(b, 1'b0, idx); // right behind its store.
            step(b);
            mem_instr(b, 1'b1, (idx + 1) % MEM_WORDS);
            b.valid = 1'b0; // bubble store leaves the ram alone.
            step(b);
            mem_instr(b, 1'b0, (idx + 1) % MEM_WORDS);
            step(b);
        end
        drain();
    endtask

    task automatic test_redirect();
        cpu_types_pkg::id_ex_t b;
        for (int k = 0; k < 4; k++) begin
            random_instr(b);
            b.alu_op = cpu_types_pkg::ALU_SUB;
            b.reg_wr = 1'b0;
            b.beq    = (k < 2);
            b.bne    = (k >= 2);
            if (k[0]) begin
                b.rdat2 = b.rdat1; // equal operands.
            end
            step(b);
        end
        random_instr(b);
        b.reg_wr = 1'b0;
        b.jump   = 1'b1;
        step(b);
        random_instr(b);
        b.reg_wr = 1'b0;
        b.jr     = 1'b1;
        step(b);
        random_instr(b);
        b.jal  = 1'b1;
        b.wsel = 5'd31;
        step(b);
        drain();
    endtask

    task automatic test_stream();
        cpu_types_pkg::id_ex_t b;
        int                    kind;
        int                    op;
        for (int n = 0; n < STREAM_LEN; n++) begin
            kind = {$random(seed)} % 6;
            op   = {$random(seed)} % 10;
            random_instr(b);
            case (kind)
                0: begin
                    b.alu_op      = op[3:0];
                    b.alu_src_imm = op[0];
                end
                1: mem_instr(b, 1'b1, {$random(seed)} % MEM_WORDS);
                2: mem_instr(b, 1'b0, {$random(seed)} % MEM_WORDS);
                3: begin
                    b.alu_op = cpu_types_pkg::ALU_SUB;
                    b.beq    = op[0];
                    b.bne    = !op[0];
                end
                4: b.valid = 1'b0;
                default: begin
                    b.jr   = (op < 3);
                    b.jump = (op >= 3 && op < 6);
                    b.jal  = (op >= 6);
                end
            endcase
            step(b);
        end
        drain();
    endtask

    task automatic test_halt();
        cpu_types_pkg::id_ex_t b;
        random_instr(b);
        b.reg_wr = 1'b0;
        b.halt   = 1'b1;
        step(b);
        repeat (3) begin
            step('0);
            random_instr(b);
            step(b);
        end
        drain();
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed       = 32'h534;
        word_errs  = 0;
        reg_errs   = 0;
        bit_errs   = 0;
        redir_errs = 0;
        s1_redir   = '0;
        s1_en      = 1'b0;
        s2_en      = 1'b0;
        s1_sel     = '0;
        s2_sel     = '0;
        s1_data    = '0;
        s2_data    = '0;
        s1_halt    = 1'b0;
        s2_halt    = 1'b0;
        exp_halt   = 1'b0;
        CLK        = 1'b0;
        nRST       = 1'b0;
        id_ex      = '0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        test_reset();
        test_alu();
        test_mem();
        test_redirect();
        test_stream();
        test_halt();
        total_errs = word_errs + reg_errs + bit_errs + redir_errs
                   + ex_mem_top_i.chk_i.assert_fails;
        $display("errors: word %0d, reg %0d, bit %0d, redirect %0d, assertion %0d",
                 word_errs, reg_errs, bit_errs, redir_errs, ex_mem_top_i.chk_i.assert_fails);
        if (total_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/alu.sv ====
// combinational alu with shifts, logic ops, signed and unsigned compare, zero flag.
`timescale 1ns/1ns

module alu (
    input  cpu_types_pkg::word_t  a,
    input  cpu_types_pkg::word_t  b,
    input  cpu_types_pkg::aluop_t op,
    input  cpu_types_pkg::shamt_t shamt,
    output cpu_types_pkg::word_t  out,
    output logic                  zero
);

    logic slt_s;
    logic slt_u;

    assign slt_s = $signed(a) < $signed(b);
    assign slt_u = a < b;

    always_comb begin
        case (op)
            cpu_types_pkg::ALU_SLL: begin
                out = b << shamt; // shifts act on rt.
            end
            cpu_types_pkg::ALU_SRL: begin
                out = b >> shamt;
            end
            cpu_types_pkg::ALU_ADD: begin
                out = a + b;
            end
            cpu_types_pkg::ALU_SUB: begin
                out = a - b;
            end
            cpu_types_pkg::ALU_AND: begin
                out = a & b;
            end
            cpu_types_pkg::ALU_OR: begin
                out = a | b;
            end
            cpu_types_pkg::ALU_XOR: begin
                out = a ^ b;
            end
            cpu_types_pkg::ALU_NOR: begin
                out = ~(a | b);
            end
            cpu_types_pkg::ALU_SLT: begin
                out = {31'b0, slt_s};
            end
            cpu_types_pkg::ALU_SLTU: begin
                out = {31'b0, slt_u};
            end
            default: begin
                out = '0; // unused codes.
            end
        endcase
    end

    assign zero = (out == '0);

endmodule

// ==== rtl/cpu_types_pkg.sv ====
// word and field types, alu operation codes, pipeline stage bundle structs.
package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  aluop_t;
    typedef logic [25:0] jaddr_t;

    localparam aluop_t ALU_SLL  = 4'd0;
    localparam aluop_t ALU_SRL  = 4'd1;
    localparam aluop_t ALU_ADD  = 4'd2;
    localparam aluop_t ALU_SUB  = 4'd3;
    localparam aluop_t ALU_AND  = 4'd4;
    localparam aluop_t ALU_OR   = 4'd5;
    localparam aluop_t ALU_XOR  = 4'd6;
    localparam aluop_t ALU_NOR  = 4'd7;
    localparam aluop_t ALU_SLT  = 4'd8;
    localparam aluop_t ALU_SLTU = 4'd9;

    // decoded instruction as handed over by the id/ex latch.
    typedef struct packed {
        logic     valid;
        aluop_t   alu_op;
        logic     alu_src_imm;
        shamt_t   shift_amt;
        logic     lui;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm_ext;
        jaddr_t   j_addr;
        word_t    pcplusfour;
        regbits_t wsel;
        logic     reg_wr;
        logic     mem_to_reg;
        logic     dren;
        logic     dwen;
        logic     beq;
        logic     bne;
        logic     jump;
        logic     jr;
        logic     jal;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_out;
        logic     zero;
        word_t    rdat1;
        word_t    rdat2;
        word_t    branch_addr;
        word_t    jump_addr;
        word_t    pcplusfour;
        regbits_t wsel;
        logic     reg_wr;
        logic     mem_to_reg;
        logic     dren;
        logic     dwen;
        logic     beq;
        logic     bne;
        logic     jump;
        logic     jr;
        logic     jal;
        logic     halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_wr;
        logic     mem_to_reg;
        logic     jal;
        logic     halt;
        regbits_t wsel;
        word_t    alu_out;
        word_t    load_data;
        word_t    pcplusfour;
    } mem_wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

// ==== rtl/ex_mem_top.sv ====
// back half of the pipeline: execute, ex/mem latch, memory, mem/wb latch.
`timescale 1ns/1ns

module ex_mem_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cpu_types_pkg::id_ex_t    id_ex,
    output cpu_types_pkg::redirect_t redirect,
    output logic                     wb_en,
    output cpu_types_pkg::regbits_t  wb_sel,
    output cpu_types_pkg::word_t     wb_data,
    output logic                     halt
);

    cpu_types_pkg::ex_mem_t ex_next;
    cpu_types_pkg::ex_mem_t ex_q;
    cpu_types_pkg::mem_wb_t mem_next;

    execute_stage execute_stage_i (
        .id_ex   (id_ex),
        .ex_next (ex_next)
    );

    exec_mem exec_mem_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .ex_next (ex_next),
        .ex_q    (ex_q)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_stage_i (
        .CLK      (CLK),
        .ex_q     (ex_q),
        .mem_next (mem_next),
        .redirect (redirect)
    );

    mem_wb mem_wb_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .mem_next (mem_next),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .halt     (halt)
    );

endmodule

// ==== rtl/exec_mem.sv ====
// ex/mem pipeline latch holding the whole execute result bundle.
`timescale 1ns/1ns

module exec_mem (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cpu_types_pkg::ex_mem_t ex_next,
    output cpu_types_pkg::ex_mem_t ex_q
);

    // every field, payload included, clears on reset.
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_next; // no stall, copied each edge.
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
// execute stage: operand select, alu, branch and jump targets, ex/mem bundle.
`timescale 1ns/1ns

module execute_stage (
    input  cpu_types_pkg::id_ex_t  id_ex,
    output cpu_types_pkg::ex_mem_t ex_next
);

    cpu_types_pkg::word_t opa;
    cpu_types_pkg::word_t opb;
    cpu_types_pkg::word_t alu_out;
    logic                 alu_zero;

    // lui puts the immediate in the upper half and clears operand a,
    // so add, or and xor all pass the loaded constant through.
    always_comb begin
        if (id_ex.lui) begin
            opa = '0;
            opb = {id_ex.imm_ext[15:0], 16'h0000};
        end else if (id_ex.alu_src_imm) begin
            opa = id_ex.rdat1;
            opb = id_ex.imm_ext;
        end else begin
            opa = id_ex.rdat1;
            opb = id_ex.rdat2;
        end
    end

    alu alu_i (
        .a     (opa),
        .b     (opb),
        .op    (id_ex.alu_op),
        .shamt (id_ex.shift_amt),
        .out   (alu_out),
        .zero  (alu_zero)
    );

    always_comb begin
        ex_next.valid       = id_ex.valid;
        ex_next.alu_out     = alu_out;
        ex_next.zero        = alu_zero;
        ex_next.rdat1       = id_ex.rdat1; // jr target.
        ex_next.rdat2       = id_ex.rdat2; // store data.
        ex_next.branch_addr = id_ex.pcplusfour + {id_ex.imm_ext[29:0], 2'b00};
        ex_next.jump_addr   = {id_ex.pcplusfour[31:28], id_ex.j_addr, 2'b00};
        ex_next.pcplusfour  = id_ex.pcplusfour;
        ex_next.wsel        = id_ex.wsel;

        // control rides along untouched.
        ex_next.reg_wr      = id_ex.reg_wr;
        ex_next.mem_to_reg  = id_ex.mem_to_reg;
        ex_next.dren        = id_ex.dren;
        ex_next.dwen        = id_ex.dwen;
        ex_next.beq         = id_ex.beq;
        ex_next.bne         = id_ex.bne;
        ex_next.jump        = id_ex.jump;
        ex_next.jr          = id_ex.jr;
        ex_next.jal         = id_ex.jal;
        ex_next.halt        = id_ex.halt;
    end

endmodule

// ==== rtl/mem_stage.sv ====
// memory stage: word data ram, load and store, pc redirect, mem/wb bundle.
`timescale 1ns/1ns

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                     CLK,
    input  cpu_types_pkg::ex_mem_t   ex_q,
    output cpu_types_pkg::mem_wb_t   mem_next,
    output cpu_types_pkg::redirect_t redirect
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    cpu_types_pkg::word_t ram [DMEM_WORDS];
    logic [ADDR_W-1:0]    daddr;
    logic                 br_taken;

    assign daddr = ex_q.alu_out[ADDR_W+1:2]; // word index, wraps.

    always_ff @(posedge CLK) begin
        if (ex_q.valid && ex_q.dwen) begin
            ram[daddr] <= ex_q.rdat2;
        end
    end

    assign br_taken = (ex_q.beq && ex_q.zero) || (ex_q.bne && !ex_q.zero);

    always_comb begin
        redirect.taken = ex_q.valid && (ex_q.jr || ex_q.jump || ex_q.jal || br_taken);
        if (ex_q.jr) begin
            redirect.target = ex_q.rdat1;
        end else if (ex_q.jump || ex_q.jal) begin
            redirect.target = ex_q.jump_addr;
        end else begin
            redirect.target = ex_q.branch_addr;
        end
    end

    always_comb begin
        mem_next.valid      = ex_q.valid;
        mem_next.reg_wr     = ex_q.reg_wr;
        mem_next.mem_to_reg = ex_q.mem_to_reg;
        mem_next.jal        = ex_q.jal;
        mem_next.halt       = ex_q.halt;
        mem_next.wsel       = ex_q.wsel;
        mem_next.alu_out    = ex_q.alu_out;
        mem_next.load_data  = ex_q.dren ? ram[daddr] : '0;
        mem_next.pcplusfour = ex_q.pcplusfour;
    end

endmodule

// ==== rtl/mem_wb.sv ====
// mem/wb pipeline latch with writeback select and sticky halt.
`timescale 1ns/1ns

module mem_wb (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cpu_types_pkg::mem_wb_t mem_next,
    output logic                   wb_en,
    output cpu_types_pkg::regbits_t wb_sel,
    output cpu_types_pkg::word_t   wb_data,
    output logic                   halt
);

    cpu_types_pkg::mem_wb_t wb_q;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_q <= '0;
        end else begin
            wb_q      <= mem_next;
            // halt latches on the first valid halt and holds.
            wb_q.halt <= wb_q.halt | (mem_next.valid & mem_next.halt);
        end
    end

    assign wb_en  = wb_q.valid & wb_q.reg_wr;
    assign wb_sel = wb_q.wsel; // decode already steers jal to r31.
    assign halt   = wb_q.halt;

    always_comb begin
        if (wb_q.jal) begin
            wb_data = wb_q.pcplusfour; // link address.
        end else if (wb_q.mem_to_reg) begin
            wb_data = wb_q.load_data;
        end else begin
            wb_data = wb_q.alu_out;
        end
    end

endmodule
